//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FLAGS     ?= --binary --timing --assert
LOG       ?= sim.log
BUILD     ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f sources.f
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

  // ====================
  // opcodes and results
  // ====================
  typedef enum logic [1:0] {
    RD_LU   = 2'd0,
    WR_LU   = 2'd1,
    FILL_LU = 2'd2  // line coming back from far memory
  } lu_op_e;

  typedef enum logic [1:0] {
    NO_RSP = 2'd0,
    HIT    = 2'd1,
    MISS   = 2'd2,
    FILL   = 2'd3
  } lu_result_e;

  typedef enum logic [1:0] {
    FM_NONE        = 2'd0,
    FILL_REQ_OP    = 2'd1,  // fetch a line
    DIRTY_EVICT_OP = 2'd2   // write back a modified line
  } fm_op_e;

  // ====================
  // external traffic
  // ====================
  typedef struct packed {
    logic                                    valid;
    lu_op_e                                  lu_op;
    logic [`ADDR_W-1:0]                      address;
    logic                                    fill_modified; // fill carries dirty data
    logic [`WORD_W-1:0]                      data;          // write word
    logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] cl_data;       // fill line
  } lu_req_t;

  typedef struct packed {
    logic                                    valid;
    lu_op_e                                  lu_op;
    lu_result_e                              lu_result;
    logic [`ADDR_W-1:0]                      address;
    logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] cl_data;
  } lu_rsp_t;

  typedef struct packed {
    logic                                    valid;
    fm_op_e                                  opcode;
    logic [`ADDR_W-1:0]                      address;
    logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] data;
  } fm_req_t;

  // ====================
  // array traffic
  // ====================
  typedef struct packed {
    logic [`NUM_WAYS-1:0][`TAG_W-1:0] tags;
    logic [`NUM_WAYS-1:0]             valid;
    logic [`NUM_WAYS-1:0]             modified;
    logic [`NUM_WAYS-1:0]             mru;
  } set_entry_t;

  typedef struct packed {
    logic              en;
    logic [`SET_W-1:0] set;
    set_entry_t        entry;
  } set_wr_t;

  typedef struct packed {
    logic                                    valid;
    logic [`SET_W+`WAY_W-1:0]                line_addr; // {set, way}
    logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] data;
  } cl_wr_t;

  // q3 pipe register between tag lookup and line access
  typedef struct packed {
    logic                                    valid;
    lu_op_e                                  lu_op;
    logic [`TAG_W-1:0]                       tag;
    logic [`SET_W-1:0]                       set;
    logic [`OFFSET_W-1:0]                    offset;
    logic [`WORD_W-1:0]                      data;
    logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] cl_data;
    logic                                    fill_modified;
    logic                                    hit;
    logic                                    miss;
    logic                                    dirty_evict;
    logic [`SET_W+`WAY_W-1:0]                line_addr;
    logic [`TAG_W-1:0]                       evict_tag;     // victim tag before the fill
  } pipe_bus_t;

endpackage

//--- cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// ====================
// cache geometry
// ====================
`define NUM_WAYS        4   // ways per set
`define NUM_SETS        8
`define WORDS_PER_LINE  4
`define WORD_W          32
`define ADDR_W          20  // tag | set | byte offset

// derived field widths
`define OFFSET_W  ($clog2(`WORDS_PER_LINE * `WORD_W / 8))  // byte offset in a line
`define SET_W     ($clog2(`NUM_SETS))
`define TAG_W     (`ADDR_W - `SET_W - `OFFSET_W)
`define WAY_W     ($clog2(`NUM_WAYS))

`endif

//--- cache_stim.txt
# op addr fill_mod data fill_line exp_result exp_line exp_fm_op exp_fm_addr exp_fm_data (hex)
# op 0 rd 1 wr 2 fill; result 1 hit 2 miss 3 fill; fm op 0 none 1 fill req 2 dirty evict
0 00080 0 00000000 0 2 0 1 00080 0
1 00104 0 deadbeef 0 2 0 1 00104 0
2 00080 0 00000000 0a0000030a0000020a0000010a000000 3 0a0000030a0000020a0000010a000000 0 00000 0
0 00088 0 00000000 0 1 0a0000030a0000020a0000010a000000 0 00000 0
2 00100 0 00000000 0b0000030b0000020b0000010b000000 3 0b0000030b0000020b0000010b000000 0 00000 0
1 00104 0 deadbeef 0 1 0 0 00000 0
0 0010c 0 00000000 0 1 0b0000030b000002deadbeef0b000000 0 00000 0
# five fills to set 1, the first one modified
2 00190 1 00000000 0c0000030c0000020c0000010c000000 3 0c0000030c0000020c0000010c000000 0 00000 0
2 00210 0 00000000 0d0000030d0000020d0000010d000000 3 0d0000030d0000020d0000010d000000 0 00000 0
2 00290 0 00000000 0e0000030e0000020e0000010e000000 3 0e0000030e0000020e0000010e000000 0 00000 0
2 00310 0 00000000 0f0000030f0000020f0000010f000000 3 0f0000030f0000020f0000010f000000 0 00000 0
2 00390 0 00000000 10000003100000021000000110000000 3 10000003100000021000000110000000 2 00190 0c0000030c0000020c0000010c000000
0 00214 0 00000000 0 1 0d0000030d0000020d0000010d000000 0 00000 0
0 0019c 0 00000000 0 2 0 1 0019c 0
0 00398 0 00000000 0 1 10000003100000021000000110000000 0 00000 0
2 00410 0 00000000 11000003110000021100000111000000 3 11000003110000021100000111000000 0 00000 0
0 00290 0 00000000 0 2 0 1 00290 0
# sets 2 and 3 interleaved
2 004a0 0 00000000 1a0000031a0000021a0000011a000000 3 1a0000031a0000021a0000011a000000 0 00000 0
2 004b0 0 00000000 1b0000031b0000021b0000011b000000 3 1b0000031b0000021b0000011b000000 0 00000 0
1 004a8 0 cafef00d 0 1 0 0 00000 0
0 004b4 0 00000000 0 1 1b0000031b0000021b0000011b000000 0 00000 0
0 004a0 0 00000000 0 1 1a000003cafef00d1a0000011a000000 0 00000 0

//--- cache_tb.sv
`include "cache_settings.svh"

module cache_tb;

  localparam int    LINE_W    = `WORDS_PER_LINE * `WORD_W;
  localparam string STIM_FILE = "cache_stim.txt";
  localparam int    LATENCY   = 2;  // falling edges from drive to check

  // one lookup with its expected response
  typedef struct packed {
    logic               valid;        // low for an idle cycle
    logic [15:0]        num;          // lookup number in the file
    logic [1:0]         op;
    logic [`ADDR_W-1:0] addr;
    logic               fill_mod;
    logic [`WORD_W-1:0] data;
    logic [LINE_W-1:0]  fill_line;
    logic [1:0]         exp_result;
    logic [LINE_W-1:0]  exp_line;
    logic [1:0]         exp_fm_op;    // 0 means no far-memory request
    logic [`ADDR_W-1:0] exp_fm_addr;
    logic [LINE_W-1:0]  exp_fm_data;
  } stim_t;

  logic               clk;
  logic               rst_n;
  cache_pkg::lu_req_t lu_req;
  cache_pkg::lu_rsp_t lu_rsp;
  cache_pkg::fm_req_t fm_req;

  stim_t  stim_q[$];           // whole file
  stim_t  exp_q[$];            // lookups in flight, oldest first
  integer seed       = 32'h677d_e591;
  int     mismatches = 0;
  int     other_errs = 0;
  logic   loaded     = 1'b0;   // starts the watchdog

  tb_clock #(.PERIOD(40)) clock_i (.clk(clk));

  cache_top dut_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .lu_req (lu_req),
    .lu_rsp (lu_rsp),
    .fm_req (fm_req)
  );

  // ====================
  // helpers
  // ====================
  function automatic string sig_name(input string sig, input stim_t e);
    if (e.valid) begin
      return $sformatf("%s (lookup %0d)", sig, e.num);
    end else begin
      return $sformatf("%s (idle cycle)", sig);
    end
  endfunction

  task automatic check_val(input string name, input logic [LINE_W-1:0] got,
                           input logic [LINE_W-1:0] want);
    if (got !== want) begin
      mismatches++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  task automatic compare_response(input stim_t e);
    logic fm_valid;
    fm_valid = e.valid && (e.exp_fm_op != 2'd0);
    check_val(sig_name("lu_rsp.valid", e), LINE_W'(lu_rsp.valid), LINE_W'(e.valid));
    check_val(sig_name("fm_req.valid", e), LINE_W'(fm_req.valid), LINE_W'(fm_valid));
    if (e.valid) begin
      check_val(sig_name("lu_rsp.lu_op", e), LINE_W'(lu_rsp.lu_op), LINE_W'(e.op));
      check_val(sig_name("lu_rsp.lu_result", e), LINE_W'(lu_rsp.lu_result),
                LINE_W'(e.exp_result));
      check_val(sig_name("lu_rsp.address", e), LINE_W'(lu_rsp.address), LINE_W'(e.addr));
      check_val(sig_name("lu_rsp.cl_data", e), lu_rsp.cl_data, e.exp_line);
    end
    if (fm_valid) begin  // only a real request carries fields worth checking
      check_val(sig_name("fm_req.opcode", e), LINE_W'(fm_req.opcode), LINE_W'(e.exp_fm_op));
      check_val(sig_name("fm_req.address", e), LINE_W'(fm_req.address),
                LINE_W'(e.exp_fm_addr));
      check_val(sig_name("fm_req.data", e), fm_req.data, e.exp_fm_data);
    end
  endtask

  task automatic drive_request(input stim_t s);
    lu_req.valid         = s.valid;
    lu_req.lu_op         = cache_pkg::lu_op_e'(s.op);
    lu_req.address       = s.addr;
    lu_req.fill_modified = s.fill_mod;
    lu_req.data          = s.data;
    lu_req.cl_data       = s.fill_line;
  endtask

  // check the oldest lookup, drive the next, then wait for the falling edge
  task automatic run_cycle(input stim_t s);
    stim_t oldest;
    if (exp_q.size() == LATENCY) begin
      oldest = exp_q.pop_front();
      compare_response(oldest);
    end
    drive_request(s);
    exp_q.push_back(s);
    @(negedge clk);
  endtask

  task automatic load_stimulus();
    int                 fd;
    int                 code;
    int                 fields;
    int                 num;
    string              text;
    stim_t              s;
    logic [1:0]         op, res, fm_op;
    logic [`ADDR_W-1:0] addr, fm_addr;
    logic               fmod;
    logic [`WORD_W-1:0] data;
    logic [LINE_W-1:0]  fill, line, fm_data;
    num = 0;
    fd  = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open stimulus file %s", STIM_FILE);
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(text, fd);
        if (code > 1 && text.getc(0) != "#") begin  // skip blank and comment lines
          num++;
          fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h", op, addr, fmod, data,
                           fill, res, line, fm_op, fm_addr, fm_data);
          if (fields == 10) begin
            s             = '0;
            s.valid       = 1'b1;
            s.num         = num[15:0];
            s.op          = op;
            s.addr        = addr;
            s.fill_mod    = fmod;
            s.data        = data;
            s.fill_line   = fill;
            s.exp_result  = res;
            s.exp_line    = line;
            s.exp_fm_op   = fm_op;
            s.exp_fm_addr = fm_addr;
            s.exp_fm_data = fm_data;
            stim_q.push_back(s);
          end else begin
            other_errs++;
            $display("stimulus lookup %0d has a wrong number of fields", num);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin : main
    stim_t idle;
    int    gap;
    int    prev_set;
    idle     = '0;
    prev_set = -1;
    rst_n    = 1'b0;
    drive_request(idle);
    load_stimulus();
    if (stim_q.size() == 0) begin
      other_errs++;
      $display("no lookups were read, so nothing was run");
    end else begin
      loaded = 1'b1;
      repeat (8) @(posedge clk);  // reset held for 8 cycles
      @(negedge clk);
      rst_n = 1'b1;
      repeat (4) run_cycle(idle);  // outputs must stay quiet here
      foreach (stim_q[i]) begin
        // same set runs back to back so the forwarding paths see it
        if (int'(stim_q[i].addr[`OFFSET_W +: `SET_W]) == prev_set) begin
          gap = 0;
        end else begin
          gap = $unsigned($random(seed)) % 3;
        end
        prev_set = int'(stim_q[i].addr[`OFFSET_W +: `SET_W]);
        repeat (gap) run_cycle(idle);
        run_cycle(stim_q[i]);
      end
      repeat (LATENCY) run_cycle(idle);  // drain the pipeline
    end
    $display("error count: %0d mismatches, %0d other errors", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog whose limit scales with the number of lookups
  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = stim_q.size() * 4 + 50;
    repeat (limit) @(posedge clk);
    other_errs++;
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("error count: %0d mismatches, %0d other errors", mismatches, other_errs);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- cache_top.sv
`include "cache_settings.svh"

module cache_top (
  input  logic                clk,
  input  logic                rst_n,
  input  cache_pkg::lu_req_t  lu_req,
  output cache_pkg::lu_rsp_t  lu_rsp,
  output cache_pkg::fm_req_t  fm_req
);

  // ====================
  // pipeline to arrays
  // ====================
  logic [`SET_W-1:0]                       set_rd_set;
  cache_pkg::set_entry_t                   set_rd;
  cache_pkg::set_wr_t                      set_wr;
  logic [`SET_W+`WAY_W-1:0]                cl_rd_addr;
  logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] cl_rd;
  cache_pkg::cl_wr_t                       cl_wr;
  cache_pkg::pipe_bus_t                    pipe_q3;  // q2 to q3

  tag_lookup tag_lookup_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .lu_req     (lu_req),
    .set_rd_set (set_rd_set),
    .set_rd     (set_rd),
    .set_wr     (set_wr),
    .cl_rd_addr (cl_rd_addr),
    .pipe_q3    (pipe_q3)
  );

  tag_array tag_array_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .set_rd_set (set_rd_set),
    .set_rd     (set_rd),
    .set_wr     (set_wr)
  );

  data_array data_array_i (
    .clk        (clk),
    .cl_rd_addr (cl_rd_addr),
    .cl_rd      (cl_rd),
    .cl_wr      (cl_wr)
  );

  line_access line_access_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .pipe_q3 (pipe_q3),
    .cl_rd   (cl_rd),
    .cl_wr   (cl_wr),
    .lu_rsp  (lu_rsp),
    .fm_req  (fm_req)
  );

endmodule

//--- data_array.sv
`include "cache_settings.svh"

module data_array (
  input  logic                                    clk,
  input  logic [`SET_W+`WAY_W-1:0]                cl_rd_addr, // {set, way} from q2
  output logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] cl_rd,      // line in q3
  input  cache_pkg::cl_wr_t                       cl_wr       // write from q3
);

  // one line per set and way
  logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] lines [`NUM_SETS * `NUM_WAYS];

  // write lands at the edge
  always_ff @(posedge clk) begin
    if (cl_wr.valid) begin
      lines[cl_wr.line_addr] <= cl_wr.data;
    end
  end

  // registered read
  always_ff @(posedge clk) begin
    cl_rd <= lines[cl_rd_addr];  // pre-write data on a collision
  end

endmodule

//--- line_access.sv
`include "cache_settings.svh"

module line_access (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  cache_pkg::pipe_bus_t                    pipe_q3,
  input  logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] cl_rd,   // data array read
  output cache_pkg::cl_wr_t                       cl_wr,
  output cache_pkg::lu_rsp_t                      lu_rsp,
  output cache_pkg::fm_req_t                      fm_req
);

  localparam int BYTE_W = $clog2(`WORD_W / 8);       // byte bits inside a word
  localparam int WOFF_W = $clog2(`WORDS_PER_LINE);

  cache_pkg::cl_wr_t                       cl_wr_q4;   // last cycle's line write
  logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] line_q3;    // line after forwarding
  logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] merged;
  logic [WOFF_W-1:0]                       word_off;
  logic                                    line_hazard;
  logic                                    is_fill;
  logic                                    is_rd_hit;
  logic                                    is_wr_hit;
  logic                                    is_miss;

  assign is_fill   = pipe_q3.valid && (pipe_q3.lu_op == cache_pkg::FILL_LU);
  assign is_rd_hit = pipe_q3.valid && (pipe_q3.lu_op == cache_pkg::RD_LU) && pipe_q3.hit;
  assign is_wr_hit = pipe_q3.valid && (pipe_q3.lu_op == cache_pkg::WR_LU) && pipe_q3.hit;
  assign is_miss   = pipe_q3.valid && pipe_q3.miss && (pipe_q3.lu_op != cache_pkg::FILL_LU);

  // ====================
  // line forwarding
  // ====================
  // array read missed the write that landed on the same edge
  assign line_hazard = cl_wr_q4.valid && (cl_wr_q4.line_addr == pipe_q3.line_addr);
  assign line_q3     = line_hazard ? cl_wr_q4.data : cl_rd;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cl_wr_q4.valid <= 1'b0;
    end else begin
      cl_wr_q4 <= cl_wr;
    end
  end

  // ====================
  // line write
  // ====================
  assign word_off = pipe_q3.offset[BYTE_W +: WOFF_W];

  always_comb begin
    merged           = line_q3;
    merged[word_off] = pipe_q3.data;  // replace one word
  end

  assign cl_wr.valid     = is_fill || is_wr_hit;
  assign cl_wr.line_addr = pipe_q3.line_addr;
  assign cl_wr.data      = is_fill ? pipe_q3.cl_data : merged;

  // ====================
  // response
  // ====================
  assign lu_rsp.valid     = pipe_q3.valid;
  assign lu_rsp.lu_op     = pipe_q3.lu_op;
  assign lu_rsp.lu_result = !pipe_q3.valid ? cache_pkg::NO_RSP :
                            is_fill        ? cache_pkg::FILL   :
                            pipe_q3.hit    ? cache_pkg::HIT    :
                                             cache_pkg::MISS;
  assign lu_rsp.address   = {pipe_q3.tag, pipe_q3.set, pipe_q3.offset};
  assign lu_rsp.cl_data   = is_fill   ? pipe_q3.cl_data :
                            is_rd_hit ? line_q3         :
                                        '0;

  // far memory request
  always_comb begin
    fm_req = '0;  // FM_NONE
    if (is_fill && pipe_q3.dirty_evict) begin
      fm_req.valid   = 1'b1;
      fm_req.opcode  = cache_pkg::DIRTY_EVICT_OP;
      fm_req.address = {pipe_q3.evict_tag, pipe_q3.set, {`OFFSET_W{1'b0}}};  // line aligned
      fm_req.data    = line_q3;  // victim line before the fill
    end else if (is_miss) begin
      fm_req.valid   = 1'b1;
      fm_req.opcode  = cache_pkg::FILL_REQ_OP;
      fm_req.address = {pipe_q3.tag, pipe_q3.set, pipe_q3.offset};
    end
  end

  // a dirty victim only comes from a fill of a tag not already in the set
  a_evict_fill : assert property (@(posedge clk) disable iff (!rst_n)
    pipe_q3.valid && pipe_q3.dirty_evict |-> is_fill && (pipe_q3.evict_tag != pipe_q3.tag));

endmodule

//--- sources.f
+incdir+.
cache_pkg.sv
tag_array.sv
data_array.sv
victim_select.sv
tag_lookup.sv
line_access.sv
cache_top.sv
tb_clock.sv
cache_tb.sv

//--- tag_array.sv
`include "cache_settings.svh"

module tag_array (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`SET_W-1:0]     set_rd_set,  // set of the q1 lookup
  output cache_pkg::set_entry_t set_rd,      // valid one cycle later
  input  cache_pkg::set_wr_t    set_wr       // update from q2
);

  cache_pkg::set_entry_t sets [`NUM_SETS]; // one entry per set

  // ====================
  // write port
  // ====================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < `NUM_SETS; s++) begin
        sets[s].valid    <= '0;
        sets[s].modified <= '0;
        sets[s].mru      <= '0;  // tags keep whatever they held
      end
    end else if (set_wr.en) begin
      sets[set_wr.set] <= set_wr.entry;
    end
  end

  // ====================
  // read port
  // ====================
  // old contents on a same-edge read and write
  // the pipeline forwards around that case
  always_ff @(posedge clk) begin
    set_rd <= sets[set_rd_set];
  end

endmodule

//--- tag_lookup.sv
`include "cache_settings.svh"

module tag_lookup (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cache_pkg::lu_req_t       lu_req,      // q1 lookup
  output logic [`SET_W-1:0]        set_rd_set,
  input  cache_pkg::set_entry_t    set_rd,
  output cache_pkg::set_wr_t       set_wr,
  output logic [`SET_W+`WAY_W-1:0] cl_rd_addr,
  output cache_pkg::pipe_bus_t     pipe_q3
);

  cache_pkg::lu_req_t    req_q2;       // q2 stage register
  cache_pkg::set_entry_t set_fwd_q3;   // copy of the last set write
  cache_pkg::set_entry_t cur_set;      // set after forwarding
  cache_pkg::set_entry_t new_set;      // updated set
  cache_pkg::pipe_bus_t  pipe_q2;

  logic [`TAG_W-1:0]    tag_q2;
  logic [`SET_W-1:0]    set_q2;
  logic                 set_hazard;
  logic                 is_fill;
  logic [`NUM_WAYS-1:0] hit_vec;
  logic [`WAY_W-1:0]    hit_way;
  logic [`NUM_WAYS-1:0] victim;
  logic [`WAY_W-1:0]    victim_way;
  logic                 dirty_evict;

  // ====================
  // q1
  // ====================
  assign set_rd_set = lu_req.address[`OFFSET_W +: `SET_W];  // tag array read starts here

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q2.valid  <= 1'b0;
      pipe_q3.valid <= 1'b0;
    end else begin
      req_q2  <= lu_req;
      pipe_q3 <= pipe_q2;
    end
  end

  // ====================
  // q2
  // ====================
  assign tag_q2  = req_q2.address[`ADDR_W-1 -: `TAG_W];
  assign set_q2  = req_q2.address[`OFFSET_W +: `SET_W];
  assign is_fill = req_q2.valid && (req_q2.lu_op == cache_pkg::FILL_LU);

  // q3 wrote this set at the edge set_rd was read
  assign set_hazard = req_q2.valid && pipe_q3.valid && (pipe_q3.set == set_q2);
  assign cur_set    = set_hazard ? set_fwd_q3 : set_rd;

  // tag compare
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      hit_vec[w] = req_q2.valid && cur_set.valid[w] && (cur_set.tags[w] == tag_q2);
      if (hit_vec[w]) begin
        hit_way = w[`WAY_W-1:0];
      end
    end
  end

  victim_select victim_select_i (
    .is_fill     (is_fill),
    .entry       (cur_set),
    .victim      (victim),
    .victim_way  (victim_way),
    .dirty_evict (dirty_evict)
  );

  // set update
  always_comb begin
    new_set = cur_set;  // misses write the set back unchanged
    if (req_q2.valid) begin
      unique case (req_q2.lu_op)
        cache_pkg::RD_LU: begin
          new_set.mru = cur_set.mru | hit_vec;
        end
        cache_pkg::WR_LU: begin
          new_set.mru      = cur_set.mru | hit_vec;
          new_set.modified = cur_set.modified | hit_vec;  // line now differs from far memory
        end
        cache_pkg::FILL_LU: begin
          new_set.tags[victim_way] = tag_q2;
          new_set.valid            = cur_set.valid | victim;
          new_set.mru              = cur_set.mru | victim;
          new_set.modified = req_q2.fill_modified ? (cur_set.modified | victim)
                                                  : (cur_set.modified & ~victim);
        end
        default: ;
      endcase
    end
    // bit-flip when all mru bits are set keeps only the way just used
    if (&new_set.mru) begin
      new_set.mru = is_fill ? victim : hit_vec;
    end
  end

  assign set_wr.en    = req_q2.valid;
  assign set_wr.set   = set_q2;
  assign set_wr.entry = new_set;

  always_ff @(posedge clk) begin
    set_fwd_q3 <= new_set;
  end

  // q2 bus toward q3
  always_comb begin
    pipe_q2.valid         = req_q2.valid;
    pipe_q2.lu_op         = req_q2.lu_op;
    pipe_q2.tag           = tag_q2;
    pipe_q2.set           = set_q2;
    pipe_q2.offset        = req_q2.address[`OFFSET_W-1:0];
    pipe_q2.data          = req_q2.data;
    pipe_q2.cl_data       = req_q2.cl_data;
    pipe_q2.fill_modified = req_q2.fill_modified;
    pipe_q2.hit           = |hit_vec;
    pipe_q2.miss          = req_q2.valid && !(|hit_vec);
    pipe_q2.dirty_evict   = dirty_evict;
    pipe_q2.line_addr     = {set_q2, is_fill ? victim_way : hit_way};
    pipe_q2.evict_tag     = cur_set.tags[victim_way];  // read before the fill overwrites it
  end

  assign cl_rd_addr = pipe_q2.line_addr;  // line arrives with pipe_q3

  // duplicate valid tags in one set would mean a broken fill path
  a_hit_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    req_q2.valid |-> $onehot0(hit_vec));

endmodule

//--- tb_clock.sv
module tb_clock #(
  parameter int PERIOD = 40  // clock period in time units
) (
  output logic clk
);

  // free running clock that starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;  // half period each phase
    end
  end

endmodule

//--- victim_select.sv
`include "cache_settings.svh"

module victim_select (
  input  logic                  is_fill,     // valid fill in q2
  input  cache_pkg::set_entry_t entry,       // set as q2 sees it
  output logic [`NUM_WAYS-1:0]  victim,      // one-hot or zero when no fill
  output logic [`WAY_W-1:0]     victim_way,
  output logic                  dirty_evict
);

  logic [`NUM_WAYS-1:0] free_ways;   // invalid ways
  logic [`NUM_WAYS-1:0] lru_ways;    // mru bit clear
  logic [`NUM_WAYS-1:0] first_free;
  logic [`NUM_WAYS-1:0] first_lru;

  assign free_ways  = ~entry.valid;
  assign lru_ways   = ~entry.mru;
  assign first_free = free_ways & -free_ways;  // isolate lowest set bit
  assign first_lru  = lru_ways & -lru_ways;

  // ====================
  // victim choice
  // ====================
  always_comb begin
    victim = '0;
    if (is_fill) begin
      victim = (|free_ways) ? first_free : first_lru;  // empty way wins
    end
  end

  // one-hot to index
  always_comb begin
    victim_way = '0;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (victim[w]) begin
        victim_way = w[`WAY_W-1:0];
      end
    end
  end

  // victim holds data far memory has not seen
  assign dirty_evict = |(victim & entry.valid & entry.modified);

  // the bit-flip in tag_lookup keeps one mru bit clear
  // so a fill into a full set always finds exactly one way
  always_comb begin
    if (is_fill) begin
      a_fill_victim : assert ($onehot(victim));
    end
  end

endmodule
